// ==== src.f ====
+incdir+design
design/pkt_check_pkg.sv
design/pkt_summarizer.sv
design/pkt_summary_fifo.sv
design/pkt_matcher.sv
design/pkt_checker_top.sv
test/tb_pkt_checker.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the packet checker testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/10ps -f src.f \
    --top-module tb_pkt_checker --Mdir obj_dir -o tb_pkt_checker
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_pkt_checker > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== test/tb_pkt_checker.sv ====
////////////////////////////////////////////////////////////////////////////
// Random testbench for the packet checker with packet model, APB tasks and watchdog
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "pkt_check_config.svh"

module tb_pkt_checker;

    import pkt_check_pkg::*;

    // Packets over all six batches with up to 16 beats each
    localparam int MAX_PKTS   = 57;
    localparam int MAX_BEATS  = MAX_PKTS * 16;
    localparam int APB_CYCLES = 3 * 300;
    localparam int LIMIT      = 4 * (MAX_BEATS + 17 * MAX_PKTS) + APB_CYCLES + 16;
    localparam int NUM        = `PKT_NUM_EXPECTED;

    logic       axis_packet_in;
    logic       rst;
    axis_beat_t beat;
    logic       tvalid;
    logic       tready;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;

    // Packets of the current batch
    logic [7:0]             pdata [64][64];
    int                     plen [64];
    logic [`PKT_DEST_W-1:0] pdest [64];
    int                     npkt;
    int                     done_q [$];

    // Model of the table and the status registers
    logic [31:0]    exp_tab [NUM];
    logic [NUM-1:0] exp_rcvd;
    int             exp_match;
    int             exp_miss;
    logic [31:0]    exp_last;

    logic [31:0]    rd;
    logic [31:0]    total;
    logic           err;
    int             pick;
    int             stall_cycles;

    pkt_checker_top pkt_checker_top_inst (
        .axis_packet_in (axis_packet_in),
        .rst            (rst),
        .beat           (beat),
        .tvalid         (tvalid),
        .tready         (tready),
        .apb_req        (apb_req),
        .apb_rsp        (apb_rsp)
    );

    always #50 axis_packet_in = !axis_packet_in;

    ////////////////////////////////////////////////////////////////////////////
    // Checks and APB access

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    // Setup and access phases with the response sampled mid-cycle
    task automatic apb_access(input logic wr, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic slverr);
        @(posedge axis_packet_in);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge axis_packet_in);
        apb_req.penable <= 1'b1;
        @(negedge axis_packet_in);
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        @(posedge axis_packet_in);
        apb_req <= '0;
    endtask

    task automatic read_check(input logic [7:0] addr, input logic [31:0] exp,
                              input string what);
        logic [31:0] r;
        logic        e;
        apb_access(1'b0, addr, '0, r, e);
        check_value(what, r, exp);
        check_value("pslverr on mapped read", 32'(e), 32'd0);
    endtask

    task automatic program_entry(input int entry, input logic [31:0] img);
        logic [31:0] r;
        logic        e;
        apb_access(1'b1, 8'(entry * 4), img, r, e);
        check_value("pslverr on entry write", 32'(e), 32'd0);
        exp_tab[entry]  = img;
        exp_rcvd[entry] = 1'b0;
    endtask

    task automatic clear_status();
        logic [31:0] r;
        logic        e;
        apb_access(1'b1, 8'h50, 32'h1, r, e);
        exp_rcvd  = '0;
        exp_match = 0;
        exp_miss  = 0;
        exp_last  = '0;
    endtask

    task automatic clear_table();
        for (int i = 0; i < NUM; i++) begin
            program_entry(i, '0);
        end
    endtask

    task automatic check_status();
        read_check(8'h40, 32'(exp_rcvd), "received bitmap");
        read_check(8'h44, 32'(exp_match), "match count");
        read_check(8'h48, 32'(exp_miss), "miss count");
        read_check(8'h4C, exp_last, "last miss");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Packet model

    // Register image with valid in 31, dest in 29:28, blen in 26:16 and checksum in 15:0
    function automatic logic [31:0] pkt_image(input int idx);
        logic [15:0] csum;
        logic [31:0] w;
        csum = '0;
        for (int k = 0; k < plen[idx]; k++) begin
            csum = csum + 16'(pdata[idx][k]);
        end
        w         = '0;
        w[31]     = 1'b1;
        w[29:28]  = pdest[idx];
        w[26:16]  = 11'(plen[idx]);
        w[15:0]   = csum;
        return w;
    endfunction

    // Random packet or a copy of an earlier one when copy_of is set
    task automatic add_packet(input int len, input int copy_of);
        if (copy_of < 0) begin
            pdest[npkt] = `PKT_DEST_W'($urandom_range(`PKT_NUM_DESTS - 1));
            plen[npkt]  = len;
        end else begin
            pdest[npkt] = pdest[copy_of];
            plen[npkt]  = plen[copy_of];
        end
        for (int k = 0; k < plen[npkt]; k++) begin
            pdata[npkt][k] = (copy_of < 0) ? 8'($urandom) : pdata[copy_of][k];
        end
        npkt++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stream driver, table prediction and completion wait

    task automatic run_batch();
        int          q [`PKT_NUM_DESTS][$];
        int          off [`PKT_NUM_DESTS];
        int          pend;
        int          d;
        int          idx;
        int          hit;
        axis_beat_t  b;
        logic [31:0] img;
        logic [31:0] m;
        logic [31:0] s;
        logic        e;
        done_q.delete();
        for (int i = 0; i < `PKT_NUM_DESTS; i++) begin
            off[i] = 0;
        end
        for (int i = 0; i < npkt; i++) begin
            q[pdest[i]].push_back(i);
        end
        pend = npkt;
        while (pend > 0) begin
            @(posedge axis_packet_in);
            if ($urandom_range(3) == 0) begin
                tvalid <= 1'b0;
            end else begin
                // Any destination with a packet still pending
                d = $urandom_range(`PKT_NUM_DESTS - 1);
                while (q[d].size() == 0) begin
                    d = (d + 1) % `PKT_NUM_DESTS;
                end
                idx = q[d][0];
                b   = '0;
                for (int j = 0; j < `PKT_DATA_BYTES; j++) begin
                    if (off[d] + j < plen[idx]) begin
                        b.tkeep[j]        = 1'b1;
                        b.tdata[j*8 +: 8] = pdata[idx][off[d] + j];
                    end
                end
                b.tdest = pdest[idx];
                b.tlast = (off[d] + `PKT_DATA_BYTES >= plen[idx]);
                beat   <= b;
                tvalid <= 1'b1;
                // Beat held until tready is seen high mid-cycle
                @(negedge axis_packet_in);
                while (!tready) begin
                    stall_cycles++;
                    @(posedge axis_packet_in);
                    @(negedge axis_packet_in);
                end
                off[d] += `PKT_DATA_BYTES;
                if (b.tlast) begin
                    done_q.push_back(idx);
                    void'(q[d].pop_front());
                    off[d] = 0;
                    pend--;
                end
            end
        end
        @(posedge axis_packet_in);
        tvalid <= 1'b0;

        // Table outcome in tlast order with the lowest free match winning
        foreach (done_q[n]) begin
            img = pkt_image(done_q[n]);
            hit = -1;
            for (int i = 0; i < NUM; i++) begin
                if (hit < 0 && exp_tab[i][31] && !exp_rcvd[i] && exp_tab[i] == img) begin
                    hit = i;
                end
            end
            if (hit >= 0) begin
                exp_rcvd[hit] = 1'b1;
                exp_match++;
            end else begin
                exp_miss++;
                exp_last = img;
            end
        end

        do begin
            apb_access(1'b0, 8'h44, '0, m, e);
            apb_access(1'b0, 8'h48, '0, s, e);
        end while (m + s < 32'(exp_match + exp_miss));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        axis_packet_in = 1'b0;
        rst            = 1'b1;
        beat           = '0;
        tvalid         = 1'b0;
        apb_req        = '0;
        npkt           = 0;
        stall_cycles   = 0;
        exp_rcvd       = '0;
        exp_match      = 0;
        exp_miss       = 0;
        exp_last       = '0;
        for (int i = 0; i < NUM; i++) begin
            exp_tab[i] = '0;
        end
        void'($urandom(32'h79887e9e));
        repeat (16) @(posedge axis_packet_in);
        rst <= 1'b0;

        // Reset state
        @(negedge axis_packet_in);
        check_value("tready after reset", 32'(tready), 32'd1);
        for (int i = 0; i < NUM; i++) begin
            read_check(8'(i * 4), '0, "table entry after reset");
        end
        check_status();

        // Twelve random packets with ten of them expected
        for (int i = 0; i < 12; i++) begin
            add_packet(1 + $urandom_range(63), -1);
        end
        for (int i = 0; i < 10; i++) begin
            program_entry(i, pkt_image(i));
        end
        run_batch();
        check_status();

        // Unmapped addresses and a rewrite of a received entry
        apb_access(1'b0, 8'h54, '0, rd, err);
        check_value("pslverr on unmapped read", 32'(err), 32'd1);
        apb_access(1'b1, 8'h60, 32'h1, rd, err);
        check_value("pslverr on unmapped write", 32'(err), 32'd1);
        pick = 0;
        while (pick < NUM - 1 && !exp_rcvd[pick]) begin
            pick++;
        end
        program_entry(pick, ($urandom & 32'h37FF_FFFF) | 32'h8000_0000);
        read_check(8'(pick * 4), exp_tab[pick], "rewritten entry");
        check_status();

        // Same packet twice against a single entry
        clear_table();
        clear_status();
        npkt = 0;
        add_packet(1 + $urandom_range(63), -1);
        add_packet(0, 0);
        program_entry(5, pkt_image(0));
        run_batch();
        check_status();

        // Two identical entries and one copy sent at a time
        clear_status();
        program_entry(5, '0);
        program_entry(2, pkt_image(0));
        program_entry(7, pkt_image(0));
        npkt = 1;
        run_batch();
        check_status();
        run_batch();
        check_status();

        // One byte burst that fills the FIFO
        clear_status();
        npkt = 0;
        for (int i = 0; i < 40; i++) begin
            add_packet(1, -1);
        end
        for (int i = 0; i < NUM; i++) begin
            program_entry(i, pkt_image(i));
        end
        stall_cycles = 0;
        run_batch();
        check_value("tready low during burst", 32'(stall_cycles > 0), 32'd1);
        check_status();
        apb_access(1'b0, 8'h44, '0, rd, err);
        total = rd;
        apb_access(1'b0, 8'h48, '0, rd, err);
        check_value("match plus miss count", total + rd, 32'd40);

        // Control clear and a packet that matches again
        clear_status();
        check_status();
        npkt = 1;
        run_batch();
        check_status();

        $display("Simulation completed successfully");
        $finish;
    end

    initial begin
        repeat (LIMIT) @(posedge axis_packet_in);
        $display("Simulation failed");
        $display("Timeout: the run did not finish within %0d clock cycles", LIMIT);
        $fatal(1, "Watchdog expired");
    end

endmodule

// ==== design/pkt_checker_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Packet checker top: summarizer, summary FIFO and matcher
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module pkt_checker_top (
    input  logic                    axis_packet_in,
    input  logic                    rst,
    input  pkt_check_pkg::axis_beat_t beat,
    input  logic                    tvalid,
    output logic                    tready,
    input  pkt_check_pkg::apb_req_t apb_req,
    output pkt_check_pkg::apb_rsp_t apb_rsp
);

    import pkt_check_pkg::*;

    // Summarizer to FIFO
    logic         push;
    logic         fifo_full;
    pkt_summary_t wr_summary;

    // FIFO to matcher
    logic         pop;
    logic         fifo_empty;
    pkt_summary_t head_summary;

    pkt_summarizer pkt_summarizer_inst (
        .axis_packet_in (axis_packet_in),
        .rst            (rst),
        .beat           (beat),
        .tvalid         (tvalid),
        .tready         (tready),
        .full           (fifo_full),
        .push           (push),
        .summary        (wr_summary)
    );

    pkt_summary_fifo pkt_summary_fifo_inst (
        .axis_packet_in (axis_packet_in),
        .rst            (rst),
        .push           (push),
        .wr_summary     (wr_summary),
        .full           (fifo_full),
        .pop            (pop),
        .rd_summary     (head_summary),
        .empty          (fifo_empty)
    );

    pkt_matcher pkt_matcher_inst (
        .axis_packet_in (axis_packet_in),
        .rst            (rst),
        .empty          (fifo_empty),
        .summary        (head_summary),
        .pop            (pop),
        .apb_req        (apb_req),
        .apb_rsp        (apb_rsp)
    );

endmodule

// ==== design/pkt_matcher.sv ====
////////////////////////////////////////////////////////////////////////////
// Expected packet table with sequential match scan, status counters
// and the APB register file
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "pkt_check_config.svh"

module pkt_matcher (
    input  logic                        axis_packet_in,
    input  logic                        rst,
    input  logic                        empty,
    input  pkt_check_pkg::pkt_summary_t summary,
    output logic                        pop,
    input  pkt_check_pkg::apb_req_t     apb_req,
    output pkt_check_pkg::apb_rsp_t     apb_rsp
);

    import pkt_check_pkg::*;

    localparam int unsigned NUM   = `PKT_NUM_EXPECTED;
    localparam int unsigned IDX_W = $clog2(NUM);
    localparam int unsigned DW    = `PKT_APB_DW;

    // Register map
    localparam logic [`PKT_APB_AW-1:0] ENTRY_END      = `PKT_APB_AW'(NUM * 4);
    localparam logic [`PKT_APB_AW-1:0] ADDR_BITMAP    = `PKT_APB_AW'('h40);
    localparam logic [`PKT_APB_AW-1:0] ADDR_MATCH     = `PKT_APB_AW'('h44);
    localparam logic [`PKT_APB_AW-1:0] ADDR_MISS      = `PKT_APB_AW'('h48);
    localparam logic [`PKT_APB_AW-1:0] ADDR_LAST_MISS = `PKT_APB_AW'('h4C);
    localparam logic [`PKT_APB_AW-1:0] ADDR_CTRL      = `PKT_APB_AW'('h50);

    // Entry image: valid 31, dest 29:28, blen 26:16, checksum 15:0
    function automatic logic [DW-1:0] entry_to_word(input expect_entry_t e);
        logic [DW-1:0] w;
        w                       = '0;
        w[31]                   = e.valid;
        w[28 +: `PKT_DEST_W]    = e.summary.dest;
        w[16 +: `PKT_BLEN_W]    = e.summary.blen;
        w[0 +: `PKT_CSUM_W]     = e.summary.checksum;
        return w;
    endfunction

    function automatic expect_entry_t word_to_entry(input logic [DW-1:0] w);
        expect_entry_t e;
        e.valid            = w[31];
        e.summary.dest     = w[28 +: `PKT_DEST_W];
        e.summary.blen     = w[16 +: `PKT_BLEN_W];
        e.summary.checksum = w[0 +: `PKT_CSUM_W];
        return e;
    endfunction

    expect_entry_t    table_q [NUM];
    logic [NUM-1:0]   rcvd;
    logic [DW-1:0]    match_cnt;
    logic [DW-1:0]    miss_cnt;
    expect_entry_t    last_miss;

    // Scan state
    pkt_summary_t     cur;
    logic             scanning;
    logic             result_pending;
    logic             found;
    logic [IDX_W-1:0] scan_idx;
    logic [IDX_W-1:0] hit_idx;
    logic             entry_hit;

    // APB decode
    logic             access;
    logic             apb_wr;
    logic             entry_sel;
    logic [IDX_W-1:0] entry_idx;
    logic             mapped;
    logic [DW-1:0]    rd_data;

    ////////////////////////////////////////////////////////////////////////////
    // Match scan

    // Takes the next summary in the same cycle the previous result lands
    assign pop = !scanning && !empty;

    assign entry_hit = table_q[scan_idx].valid && !rcvd[scan_idx]
                       && (table_q[scan_idx].summary == cur);

    always_ff @(posedge axis_packet_in) begin
        if (rst) begin
            scanning       <= 1'b0;
            result_pending <= 1'b0;
            found          <= 1'b0;
            scan_idx       <= '0;
            rcvd           <= '0;
            match_cnt      <= '0;
            miss_cnt       <= '0;
            last_miss      <= '0;
            for (int i = 0; i < NUM; i++) begin
                table_q[i] <= '0;
            end
        end else begin
            result_pending <= 1'b0;
            if (pop) begin
                scanning <= 1'b1;
                scan_idx <= '0;
                found    <= 1'b0;
            end else if (scanning) begin
                // Lowest index wins
                if (entry_hit && !found) begin
                    found <= 1'b1;
                end
                if (scan_idx == IDX_W'(NUM - 1)) begin
                    scanning       <= 1'b0;
                    result_pending <= 1'b1;
                end
                scan_idx <= scan_idx + IDX_W'(1);
            end

            // Result of the finished scan
            if (result_pending) begin
                if (found) begin
                    rcvd[hit_idx] <= 1'b1;
                    match_cnt     <= match_cnt + DW'(1);
                end else begin
                    miss_cnt          <= miss_cnt + DW'(1);
                    last_miss.valid   <= 1'b1;
                    last_miss.summary <= cur;
                end
            end

            // Software writes
            if (apb_wr) begin
                if (entry_sel) begin
                    table_q[entry_idx] <= word_to_entry(apb_req.pwdata);
                    rcvd[entry_idx]    <= 1'b0;
                end else if (apb_req.paddr == ADDR_CTRL && apb_req.pwdata[0]) begin
                    rcvd      <= '0;
                    match_cnt <= '0;
                    miss_cnt  <= '0;
                    last_miss <= '0;
                end
            end
        end
    end

    // Summary under test and the hit position
    always_ff @(posedge axis_packet_in) begin
        if (pop) begin
            cur <= summary;
        end
        if (scanning && entry_hit && !found) begin
            hit_idx <= scan_idx;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // APB register file

    assign access    = apb_req.psel && apb_req.penable;
    assign apb_wr    = access && apb_req.pwrite;
    assign entry_sel = (apb_req.paddr < ENTRY_END) && (apb_req.paddr[1:0] == 2'b00);
    assign entry_idx = apb_req.paddr[2 +: IDX_W];

    always_comb begin
        rd_data = '0;
        mapped  = 1'b1;
        if (entry_sel) begin
            rd_data = entry_to_word(table_q[entry_idx]);
        end else begin
            case (apb_req.paddr)
                ADDR_BITMAP:    rd_data = DW'(rcvd);
                ADDR_MATCH:     rd_data = match_cnt;
                ADDR_MISS:      rd_data = miss_cnt;
                ADDR_LAST_MISS: rd_data = entry_to_word(last_miss);
                // Control is write only and reads as zero
                ADDR_CTRL:      rd_data = '0;
                default:        mapped  = 1'b0;
            endcase
        end
    end

    assign apb_rsp.prdata  = rd_data;
    assign apb_rsp.pslverr = access && !mapped;

endmodule

// ==== design/pkt_summary_fifo.sv ====
////////////////////////////////////////////////////////////////////////////
// First-word-fall-through FIFO of packet summaries
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "pkt_check_config.svh"

module pkt_summary_fifo (
    input  logic                        axis_packet_in,
    input  logic                        rst,
    input  logic                        push,
    input  pkt_check_pkg::pkt_summary_t wr_summary,
    output logic                        full,
    input  logic                        pop,
    output pkt_check_pkg::pkt_summary_t rd_summary,
    output logic                        empty
);

    import pkt_check_pkg::*;

    localparam int unsigned DEPTH = `PKT_FIFO_DEPTH;
    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    pkt_summary_t     mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    assign wr_en = push && (count != CNT_W'(DEPTH));
    assign rd_en = pop && !empty;

    // Head falls through
    assign rd_summary = mem[rd_ptr];
    assign empty      = (count == '0);

    // Last free slot is taken when a push is in flight
    assign full = (count == CNT_W'(DEPTH)) || ((count == CNT_W'(DEPTH - 1)) && push);

    always_ff @(posedge axis_packet_in) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge axis_packet_in) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_summary;
        end
    end

endmodule

// ==== design/pkt_summarizer.sv ====
////////////////////////////////////////////////////////////////////////////
// Per-destination byte count and checksum of stream beats, summary at tlast
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "pkt_check_config.svh"

module pkt_summarizer (
    input  logic                        axis_packet_in,
    input  logic                        rst,
    input  pkt_check_pkg::axis_beat_t   beat,
    input  logic                        tvalid,
    output logic                        tready,
    input  logic                        full,
    output logic                        push,
    output pkt_check_pkg::pkt_summary_t summary
);

    import pkt_check_pkg::*;

    logic                   accept;
    logic                   accept_last;

    // Running totals, one pair per destination
    logic [`PKT_BLEN_W-1:0] blen_acc [`PKT_NUM_DESTS];
    logic [`PKT_CSUM_W-1:0] csum_acc [`PKT_NUM_DESTS];

    logic [`PKT_BLEN_W-1:0] beat_bytes;
    logic [`PKT_CSUM_W-1:0] beat_sum;
    pkt_summary_t           next_summary;

    ////////////////////////////////////////////////////////////////////////////
    // Handshake

    // Full already counts a summary on its way in
    assign tready      = !full;
    assign accept      = tvalid && tready;
    assign accept_last = accept && beat.tlast;

    ////////////////////////////////////////////////////////////////////////////
    // Beat contribution

    // Kept bytes fill from the low lanes, but count each lane anyway
    always_comb begin
        beat_bytes = '0;
        beat_sum   = '0;
        for (int b = 0; b < `PKT_DATA_BYTES; b++) begin
            if (beat.tkeep[b]) begin
                beat_bytes = beat_bytes + `PKT_BLEN_W'(1);
                beat_sum   = beat_sum + `PKT_CSUM_W'(beat.tdata[b*8 +: 8]);
            end
        end
    end

    // Totals including this beat
    always_comb begin
        next_summary.dest     = beat.tdest;
        next_summary.blen     = blen_acc[beat.tdest] + beat_bytes;
        next_summary.checksum = csum_acc[beat.tdest] + beat_sum;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Accumulators and push

    always_ff @(posedge axis_packet_in) begin
        if (rst) begin
            push <= 1'b0;
            for (int d = 0; d < `PKT_NUM_DESTS; d++) begin
                blen_acc[d] <= '0;
                csum_acc[d] <= '0;
            end
        end else begin
            push <= accept_last;
            if (accept) begin
                if (beat.tlast) begin
                    // Destination starts its next packet from zero
                    blen_acc[beat.tdest] <= '0;
                    csum_acc[beat.tdest] <= '0;
                end else begin
                    blen_acc[beat.tdest] <= next_summary.blen;
                    csum_acc[beat.tdest] <= next_summary.checksum;
                end
            end
        end
    end

    // Finished summary, presented with push one cycle after tlast
    always_ff @(posedge axis_packet_in) begin
        if (accept_last) begin
            summary <= next_summary;
        end
    end

endmodule

// ==== design/pkt_check_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Packed types for stream beats, packet summaries, table entries and APB
////////////////////////////////////////////////////////////////////////////

`include "pkt_check_config.svh"

package pkt_check_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Stream side

    // One AXI-Stream beat, 39 bits
    typedef struct packed {
        logic [`PKT_DATA_BYTES*8-1:0] tdata;
        logic [`PKT_DATA_BYTES-1:0]   tkeep;
        logic [`PKT_DEST_W-1:0]       tdest;
        logic                         tlast;
    } axis_beat_t;

    // Finished packet, 29 bits
    typedef struct packed {
        logic [`PKT_DEST_W-1:0] dest;
        logic [`PKT_BLEN_W-1:0] blen;
        logic [`PKT_CSUM_W-1:0] checksum;
    } pkt_summary_t;

    // Expected table entry
    typedef struct packed {
        logic         valid;
        pkt_summary_t summary;
    } expect_entry_t;

    ////////////////////////////////////////////////////////////////////////////
    // APB side

    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`PKT_APB_AW-1:0] paddr;
        logic [`PKT_APB_DW-1:0] pwdata;
    } apb_req_t;

    // Valid in the access phase, no wait states
    typedef struct packed {
        logic [`PKT_APB_DW-1:0] prdata;
        logic                   pslverr;
    } apb_rsp_t;

endpackage

// ==== design/pkt_check_config.svh ====
////////////////////////////////////////////////////////////////////////////
// Sizing macros for the packet checker: stream, table, FIFO and APB widths
////////////////////////////////////////////////////////////////////////////

`ifndef PKT_CHECK_CONFIG_SVH
`define PKT_CHECK_CONFIG_SVH

// Stream beat width in bytes, sets tdata and tkeep
`define PKT_DATA_BYTES 4

// Destinations carried on tdest
`define PKT_NUM_DESTS 4
`define PKT_DEST_W 2

// Byte length field, covers an MTU of 1500
`define PKT_BLEN_W 11

// Additive checksum over the kept bytes
`define PKT_CSUM_W 16

// Expected packet table entries
`define PKT_NUM_EXPECTED 16

// Summary FIFO entries
`define PKT_FIFO_DEPTH 8

// APB address and data widths
`define PKT_APB_AW 8
`define PKT_APB_DW 32

`endif
